// ==== dv/rvx_exec_ref.svh ====
/*
  Reference model, instruction encoders and Galois LFSR for the execute unit testbench.
  Included inside the testbench module, where lfsr_state is declared.
*/
`ifndef RVX_EXEC_REF_SVH
`define RVX_EXEC_REF_SVH

// --------------------------------------------------
// Random source
// --------------------------------------------------

// Right-shifting Galois LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic [31:0] shifted;
  shifted = state >> 1;
  if (state[0]) begin
    shifted = shifted ^ 32'h8020_0003;
  end
  return shifted;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] random_bits(input int count);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < count; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    value = {value[30:0], lfsr_state[0]};
  end
  return value;
endfunction

// --------------------------------------------------
// Instruction encoders, rs1 is x1 and rs2 is x2
// --------------------------------------------------

function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                         input logic [4:0] rd);
  return {funct7, 5'd2, 5'd1, funct3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [2:0] funct3,
                                         input logic [4:0] rd, input logic [6:0] opcode);
  return {imm, 5'd1, funct3, rd, opcode};
endfunction

function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opcode);
  return {imm, rd, opcode};
endfunction

function automatic logic [31:0] encode_j(input logic [20:0] offset, input logic [4:0] rd);
  return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] encode_b(input logic [12:0] offset, input logic [2:0] funct3);
  return {offset[12], offset[10:5], 5'd2, 5'd1, funct3, offset[4:1], offset[11], 7'b1100011};
endfunction

// --------------------------------------------------
// Expected results from the RV32I rules
// --------------------------------------------------

function automatic logic [31:0] model_alu(input logic [2:0] funct3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
  case (funct3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'b0, $signed(a) < $signed(b)};
    3'd3: return {31'b0, a < b};
    3'd4: return a ^ b;
    3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// data_defined is low where rd_data carries no meaning
function automatic rvx_exec_pkg::exec_result_t model_result(
    input logic [31:0] instr, input logic [31:0] pc, input logic [31:0] rs1,
    input logic [31:0] rs2, output logic data_defined);
  rvx_exec_pkg::exec_result_t r;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic        legal;
  logic        is_branch;
  logic        cond;
  f3 = instr[14:12];
  f7 = instr[31:25];
  imm_i = {{20{instr[31]}}, instr[31:20]};
  imm_u = {instr[31:12], 12'b0};
  r = '0;
  r.rd_address = instr[11:7];
  r.next_pc = pc + 32'(`RVX_PC_STEP);
  legal = 1'b1;
  is_branch = 1'b0;
  cond = 1'b0;
  case (instr[6:0])
    7'b0110011: begin
      legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      r.rd_data = model_alu(f3, f7[5], rs1, rs2);
    end
    7'b0010011: begin
      if (f3 == 3'd1) begin
        legal = (f7 == 7'h00);
      end else if (f3 == 3'd5) begin
        legal = (f7 == 7'h00) || (f7 == 7'h20);
      end
      r.rd_data = model_alu(f3, (f3 == 3'd5) && f7[5], rs1, imm_i);
    end
    7'b0110111: r.rd_data = imm_u;
    7'b0010111: r.rd_data = pc + imm_u;
    7'b1101111: begin
      r.rd_data = pc + 32'(`RVX_PC_STEP);
      r.next_pc = pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    end
    7'b1100111: begin
      r.rd_data = pc + 32'(`RVX_PC_STEP);
      r.next_pc = (rs1 + imm_i) & ~32'd1;
    end
    7'b1100011: begin
      is_branch = 1'b1;
      case (f3)
        3'b000: cond = (rs1 == rs2);
        3'b001: cond = (rs1 != rs2);
        3'b100: cond = $signed(rs1) < $signed(rs2);
        3'b101: cond = $signed(rs1) >= $signed(rs2);
        3'b110: cond = rs1 < rs2;
        3'b111: cond = rs1 >= rs2;
        default: legal = 1'b0;
      endcase
      if (cond) begin
        r.next_pc = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
    end
    default: legal = 1'b0;
  endcase
  r.illegal = !legal;
  r.rd_write = legal && !is_branch && (r.rd_address != 5'd0);
  data_defined = legal && !is_branch;
  return r;
endfunction

`endif

// ==== dv/rvx_exec_tb.sv ====
/*
  Testbench of the RV32I execute unit. Runs req/ack transactions from the falling edge;
  concurrent assertions compare each result with the reference model and watch the handshake.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rvx_config.svh"

module rvx_exec_tb;

  localparam int ACK_TIMEOUT = 20;

  logic                        clock;
  logic                        reset_n;
  logic                        req;
  rvx_exec_pkg::exec_request_t request;
  logic                        ack;
  rvx_exec_pkg::exec_result_t  result;

  rvx_exec_pkg::exec_result_t  expected;
  logic                        check_data;
  string                       test_name;
  logic [31:0]                 lfsr_state;
  logic                        aborted;
  int                          error_count;
  int                          test_count;
  int                          transaction_count;
  int                          errors_at_start;
  int                          transactions_at_start;

  `include "rvx_exec_ref.svh"

  rvx_exec rvx_exec_i (
    .clock  (clock),
    .reset_n(reset_n),
    .req    (req),
    .request(request),
    .ack    (ack),
    .result (result)
  );

  always #20 clock = ~clock;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  function automatic logic result_ok(input rvx_exec_pkg::exec_result_t actual);
    logic same;
    same = (actual.rd_address == expected.rd_address) && (actual.rd_write == expected.rd_write)
        && (actual.next_pc == expected.next_pc) && (actual.illegal == expected.illegal);
    if (check_data) begin
      same = same && (actual.rd_data == expected.rd_data);
    end
    return same;
  endfunction

  result_matches: assert property (@(posedge clock) disable iff (!reset_n)
    $rose(ack) |-> result_ok(result))
    else begin
      error_count++;
      $display("Mismatch in %s: expected %h, actual %h", test_name, expected, result);
    end

  ack_low_after_reset: assert property (@(posedge clock) $rose(reset_n) |-> !ack)
    else begin
      error_count++;
      $display("Error in %s: ack was high when reset was released", test_name);
    end

  ack_after_req: assert property (@(posedge clock) disable iff (!reset_n)
    $rose(ack) |-> $past(req))
    else begin
      error_count++;
      $display("Error in %s: ack rose although req was low", test_name);
    end

  ack_quiet_without_req: assert property (@(posedge clock) disable iff (!reset_n)
    (!ack && !req) |=> !ack)
    else begin
      error_count++;
      $display("Error in %s: ack rose without a request", test_name);
    end

  ack_held_while_req: assert property (@(posedge clock) disable iff (!reset_n)
    (ack && req) |=> ack)
    else begin
      error_count++;
      $display("Error in %s: ack fell while req was still high", test_name);
    end

  ack_released: assert property (@(posedge clock) disable iff (!reset_n)
    (ack && !req) |=> !ack)
    else begin
      error_count++;
      $display("Error in %s: ack stayed high after req dropped", test_name);
    end

  result_stable: assert property (@(posedge clock) disable iff (!reset_n)
    (ack && $past(ack)) |-> $stable(result))
    else begin
      error_count++;
      $display("Error in %s: result changed while ack was high", test_name);
    end

  // --------------------------------------------------
  // Transaction driver
  // --------------------------------------------------

  // hold_cycles keeps req high after ack has been seen
  task automatic run_transaction(input logic [31:0] instruction, input logic [31:0] pc,
                                 input logic [31:0] rs1_data, input logic [31:0] rs2_data,
                                 input int hold_cycles);
    int   wait_cycles;
    logic defined;
    if (!aborted) begin
      @(negedge clock);
      request.instruction = instruction;
      request.pc = pc;
      request.rs1_data = rs1_data;
      request.rs2_data = rs2_data;
      expected = model_result(instruction, pc, rs1_data, rs2_data, defined);
      check_data = defined;
      req = 1'b1;
      wait_cycles = 0;
      while (!ack && wait_cycles < ACK_TIMEOUT) begin
        @(negedge clock);
        wait_cycles++;
      end
      if (!ack) begin
        $display("Timeout in %s: ack did not rise after req", test_name);
        aborted = 1'b1;
      end
      for (int i = 0; i < hold_cycles && !aborted; i++) begin
        @(negedge clock);
      end
      req = 1'b0;
      wait_cycles = 0;
      while (ack && wait_cycles < ACK_TIMEOUT) begin
        @(negedge clock);
        wait_cycles++;
      end
      if (ack) begin
        $display("Timeout in %s: ack did not fall after req dropped", test_name);
        aborted = 1'b1;
      end
      transaction_count++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = error_count;
    transactions_at_start = transaction_count;
  endtask

  task automatic end_test();
    test_count++;
    $display("Test %s: %0d transactions, %0d errors%s", test_name,
             transaction_count - transactions_at_start, error_count - errors_at_start,
             aborted ? ", stopped by timeout" : "");
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  task automatic test_op_register();
    logic [2:0] funct3;
    logic [6:0] funct7;
    start_test("op_register");
    for (int i = 0; i < 40; i++) begin
      funct3 = 3'(random_bits(3));
      funct7 = 7'h00;
      if ((funct3 == 3'd0 || funct3 == 3'd5) && random_bits(1) != 32'd0) begin
        funct7 = 7'h20;
      end
      run_transaction(encode_r(funct7, funct3, 5'(random_bits(5))), random_bits(32) & ~32'd3,
                      random_bits(32), random_bits(32), 0);
    end
    end_test();
  endtask

  task automatic test_immediate();
    logic [2:0]  funct3;
    logic [11:0] imm;
    start_test("immediate_and_upper");
    for (int i = 0; i < 20; i++) begin
      funct3 = 3'(random_bits(3));
      imm = 12'(random_bits(12));
      if (funct3 == 3'd1 || funct3 == 3'd5) begin
        imm[11:5] = (funct3 == 3'd5 && imm[11]) ? 7'h20 : 7'h00;
      end
      run_transaction(encode_i(imm, funct3, 5'(random_bits(5)), 7'b0010011),
                      random_bits(32) & ~32'd3, random_bits(32), random_bits(32), 0);
    end
    for (int i = 0; i < 12; i++) begin
      run_transaction(encode_u(20'(random_bits(20)), 5'(random_bits(5)),
                               (i % 2 == 0) ? 7'b0110111 : 7'b0010111),
                      random_bits(32) & ~32'd3, random_bits(32), random_bits(32), 0);
    end
    end_test();
  endtask

  task automatic test_branches();
    logic [31:0] left_values [5];
    logic [31:0] right_values [5];
    logic [2:0]  conditions [6];
    start_test("branches");
    // Equal, less, greater, and pairs where signed and unsigned order differ
    left_values = '{32'd5, 32'd3, 32'd9, 32'hFFFF_FFF0, 32'd5};
    right_values = '{32'd5, 32'd9, 32'd3, 32'd5, 32'hFFFF_FFF0};
    conditions = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 5; p++) begin
        run_transaction(encode_b(13'(random_bits(12)) << 1, conditions[c]),
                        random_bits(32) & ~32'd3, left_values[p], right_values[p], 0);
      end
    end
    end_test();
  endtask

  task automatic test_jumps();
    logic [4:0] rd;
    start_test("jumps");
    for (int i = 0; i < 16; i++) begin
      rd = (i < 2) ? 5'd0 : 5'(random_bits(5));
      if (i % 2 == 0) begin
        run_transaction(encode_j(21'(random_bits(20)) << 1, rd), random_bits(32) & ~32'd3,
                        random_bits(32), random_bits(32), 0);
      end else begin
        run_transaction(encode_i(12'(random_bits(12)), 3'd0, rd, 7'b1100111),
                        random_bits(32) & ~32'd3, random_bits(32), random_bits(32), 0);
      end
    end
    end_test();
  endtask

  task automatic test_illegal();
    logic [31:0] words [12];
    start_test("illegal");
    words = '{encode_u(20'h12345, 5'd3, 7'b0000011), encode_u(20'h12345, 5'd3, 7'b0100011),
              encode_u(20'h12345, 5'd3, 7'b1110011), encode_u(20'h12345, 5'd3, 7'b0001111),
              encode_u(20'h12345, 5'd3, 7'b1111111), encode_r(7'h01, 3'd0, 5'd4),
              encode_r(7'h20, 3'd1, 5'd4), encode_r(7'h20, 3'd7, 5'd4),
              encode_i(12'h403, 3'd1, 5'd6, 7'b0010011), encode_i(12'h023, 3'd5, 5'd6, 7'b0010011),
              encode_b(13'h10, 3'd2), encode_b(13'h10, 3'd3)};
    for (int i = 0; i < 12; i++) begin
      run_transaction(words[i], random_bits(32) & ~32'd3, random_bits(32), random_bits(32), 0);
    end
    end_test();
  endtask

  task automatic test_handshake();
    start_test("handshake");
    // Idle stretch with req low
    for (int i = 0; i < 6; i++) begin
      @(negedge clock);
    end
    for (int hold = 1; hold < 5; hold++) begin
      run_transaction(encode_r(7'h00, 3'(random_bits(3)), 5'd7), random_bits(32) & ~32'd3,
                      random_bits(32), random_bits(32), hold);
    end
    end_test();
  endtask

  initial begin
    clock = 1'b0;
    reset_n = 1'b0;
    req = 1'b0;
    request = '0;
    expected = '0;
    check_data = 1'b0;
    test_name = "reset";
    lfsr_state = 32'd49;
    aborted = 1'b0;
    error_count = 0;
    test_count = 0;
    transaction_count = 0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;

    test_op_register();
    test_immediate();
    test_branches();
    test_jumps();
    test_illegal();
    test_handshake();

    $display("Summary: %0d tests, %0d transactions, %0d errors", test_count,
             transaction_count, error_count);
    if (error_count == 0 && !aborted) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
+incdir+dv
src/rvx_isa_pkg.sv
src/rvx_exec_pkg.sv
src/rvx_decoder.sv
src/rvx_alu.sv
src/rvx_branch.sv
src/rvx_writeback.sv
src/rvx_exec.sv
dv/rvx_exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the execute unit testbench with Verilator; the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 -f filelist.f --top-module rvx_exec_tb -o rvx_exec_sim \
  > sim.log 2>&1 \
  && ./obj_dir/rvx_exec_sim >> sim.log 2>&1 \
  || echo "Something failed" >> sim.log
cat sim.log
! grep -q "Something failed" sim.log

// ==== src/rvx_alu.sv ====
/*
  Integer ALU for the OP and OP-IMM groups; the second operand is rs2 or the immediate.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rvx_config.svh"

module rvx_alu (
  input  rvx_exec_pkg::alu_op_e alu_op,
  input  logic                  use_immediate,
  input  logic [`RVX_XLEN-1:0]  rs1_data,
  input  logic [`RVX_XLEN-1:0]  rs2_data,
  input  logic [`RVX_XLEN-1:0]  immediate,
  output logic [`RVX_XLEN-1:0]  alu_result
);

  logic [`RVX_XLEN-1:0]        operand_b;
  logic [`RVX_SHAMT_WIDTH-1:0] shift_amount;
  logic                        less_signed;
  logic                        less_unsigned;

  // Operand selection
  // --------------------------------------------------

  assign operand_b    = use_immediate ? immediate : rs2_data;
  assign shift_amount = operand_b[`RVX_SHAMT_WIDTH-1:0];

  // Shared by SLT and SLTU
  assign less_signed   = $signed(rs1_data) < $signed(operand_b);
  assign less_unsigned = rs1_data < operand_b;

  // Result
  // --------------------------------------------------

  always_comb begin
    case (alu_op)
      rvx_exec_pkg::alu_add:
        alu_result = rs1_data + operand_b;
      rvx_exec_pkg::alu_sub:
        alu_result = rs1_data - operand_b;
      rvx_exec_pkg::alu_sll:
        alu_result = rs1_data << shift_amount;
      rvx_exec_pkg::alu_slt:
        alu_result = {{(`RVX_XLEN-1){1'b0}}, less_signed};
      rvx_exec_pkg::alu_sltu:
        alu_result = {{(`RVX_XLEN-1){1'b0}}, less_unsigned};
      rvx_exec_pkg::alu_xor:
        alu_result = rs1_data ^ operand_b;
      rvx_exec_pkg::alu_srl:
        alu_result = rs1_data >> shift_amount;
      rvx_exec_pkg::alu_sra:
        alu_result = $unsigned($signed(rs1_data) >>> shift_amount);
      rvx_exec_pkg::alu_or:
        alu_result = rs1_data | operand_b;
      rvx_exec_pkg::alu_and:
        alu_result = rs1_data & operand_b;
      // Unused encodings fall back to add
      default:
        alu_result = rs1_data + operand_b;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/rvx_branch.sv ====
/*
  Branch condition evaluation and the shared target adder for branches, jumps and AUIPC.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rvx_config.svh"

module rvx_branch (
  input  logic                        branch,
  input  logic                        jump,
  input  logic                        jump_register,
  input  rvx_isa_pkg::branch_funct3_e branch_funct3,
  input  logic [`RVX_XLEN-1:0]        pc,
  input  logic [`RVX_XLEN-1:0]        rs1_data,
  input  logic [`RVX_XLEN-1:0]        rs2_data,
  input  logic [`RVX_XLEN-1:0]        immediate,
  output logic                        taken,
  output logic [`RVX_XLEN-1:0]        target
);

  logic                 condition;
  logic [`RVX_XLEN-1:0] base;
  logic [`RVX_XLEN-1:0] sum;

  // --------------------------------------------------
  // Condition and taken
  // --------------------------------------------------

  always_comb begin
    case (branch_funct3)
      rvx_isa_pkg::beq:  condition = (rs1_data == rs2_data);
      rvx_isa_pkg::bne:  condition = (rs1_data != rs2_data);
      rvx_isa_pkg::blt:  condition = $signed(rs1_data) < $signed(rs2_data);
      rvx_isa_pkg::bge:  condition = $signed(rs1_data) >= $signed(rs2_data);
      rvx_isa_pkg::bltu: condition = rs1_data < rs2_data;
      rvx_isa_pkg::bgeu: condition = rs1_data >= rs2_data;
      // Reserved encodings, flagged illegal by the decoder
      default:           condition = 1'b0;
    endcase
    taken = jump || (branch && condition);
    // Decoder marks exactly one kind of control transfer
    assert (!taken || (branch != jump))
      else $error("branch: taken without exactly one of branch and jump");
  end

  // --------------------------------------------------
  // Target adder
  // --------------------------------------------------

  // JALR adds to rs1 and drops bit 0, all else is pc relative
  assign base   = jump_register ? rs1_data : pc;
  assign sum    = base + immediate;
  assign target = jump_register ? {sum[`RVX_XLEN-1:1], 1'b0} : sum;

endmodule

`default_nettype wire

// ==== src/rvx_config.svh ====
/*
  Widths and fixed constants of the RV32I execute unit, shared by packages and RTL.
*/
`ifndef RVX_CONFIG_SVH
`define RVX_CONFIG_SVH

// Data path
`define RVX_XLEN 32
`define RVX_INSTR_WIDTH 32
`define RVX_REG_ADDR_WIDTH 5
`define RVX_SHAMT_WIDTH 5

// Instruction fields
`define RVX_OPCODE_WIDTH 7
`define RVX_FUNCT3_WIDTH 3
`define RVX_FUNCT7_WIDTH 7

// funct7 values accepted in the OP and OP-IMM groups
`define RVX_FUNCT7_BASE 7'b0000000
`define RVX_FUNCT7_ALT 7'b0100000

// Sequential program counter increment
`define RVX_PC_STEP 4

`endif

// ==== src/rvx_decoder.sv ====
/*
  Combinational RV32I decoder: builds the control struct and the sign-extended
  immediate for the ALU, branch unit and write-back stage.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rvx_config.svh"

module rvx_decoder (
  input  logic [`RVX_INSTR_WIDTH-1:0] instruction,
  output rvx_exec_pkg::decoded_t      decoded,
  output logic [`RVX_XLEN-1:0]        immediate
);

  rvx_isa_pkg::opcode_e       opcode;
  rvx_isa_pkg::alu_funct3_e   alu_funct3;
  logic [`RVX_FUNCT7_WIDTH-1:0] funct7;
  logic                       funct7_base;
  logic                       funct7_alt;
  logic                       is_register;  // OP group, OP-IMM otherwise
  rvx_exec_pkg::alu_op_e      alu_op;
  logic                       funct7_ok;
  logic                       writes_rd;

  assign opcode      = rvx_isa_pkg::opcode_e'(instruction[6:0]);
  assign alu_funct3  = rvx_isa_pkg::alu_funct3_e'(instruction[14:12]);
  assign funct7      = instruction[31:25];
  assign funct7_base = (funct7 == `RVX_FUNCT7_BASE);
  assign funct7_alt  = (funct7 == `RVX_FUNCT7_ALT);
  assign is_register = (opcode == rvx_isa_pkg::opcode_op);

  // --------------------------------------------------
  // Immediate formats
  // --------------------------------------------------

  always_comb begin
    case (opcode)
      rvx_isa_pkg::opcode_lui, rvx_isa_pkg::opcode_auipc:
        immediate = {instruction[31:12], 12'b0};
      rvx_isa_pkg::opcode_jal:
        immediate = {{(`RVX_XLEN-20){instruction[31]}}, instruction[19:12],
                     instruction[20], instruction[30:21], 1'b0};
      rvx_isa_pkg::opcode_branch:
        immediate = {{(`RVX_XLEN-12){instruction[31]}}, instruction[7],
                     instruction[30:25], instruction[11:8], 1'b0};
      default:
        immediate = {{(`RVX_XLEN-12){instruction[31]}}, instruction[31:20]};
    endcase
  end

  // ALU operation; in OP-IMM funct7 is immediate data except for shifts
  always_comb begin
    alu_op    = rvx_exec_pkg::alu_add;
    funct7_ok = funct7_base || !is_register;
    case (alu_funct3)
      rvx_isa_pkg::funct3_add_sub: begin
        alu_op    = (is_register && funct7_alt) ? rvx_exec_pkg::alu_sub : rvx_exec_pkg::alu_add;
        funct7_ok = funct7_base || funct7_alt || !is_register;
      end
      rvx_isa_pkg::funct3_sll: begin
        alu_op    = rvx_exec_pkg::alu_sll;
        funct7_ok = funct7_base;
      end
      rvx_isa_pkg::funct3_slt:  alu_op = rvx_exec_pkg::alu_slt;
      rvx_isa_pkg::funct3_sltu: alu_op = rvx_exec_pkg::alu_sltu;
      rvx_isa_pkg::funct3_xor:  alu_op = rvx_exec_pkg::alu_xor;
      rvx_isa_pkg::funct3_srl_sra: begin
        alu_op    = funct7_alt ? rvx_exec_pkg::alu_sra : rvx_exec_pkg::alu_srl;
        funct7_ok = funct7_base || funct7_alt;
      end
      rvx_isa_pkg::funct3_or:   alu_op = rvx_exec_pkg::alu_or;
      rvx_isa_pkg::funct3_and:  alu_op = rvx_exec_pkg::alu_and;
    endcase
  end

  // --------------------------------------------------
  // Control struct
  // --------------------------------------------------

  always_comb begin
    decoded               = '0;
    writes_rd             = 1'b0;
    decoded.alu_op        = alu_op;
    decoded.branch_funct3 = rvx_isa_pkg::branch_funct3_e'(instruction[14:12]);
    decoded.rd_address    = instruction[11:7];
    case (opcode)
      rvx_isa_pkg::opcode_op: begin
        decoded.illegal = !funct7_ok;
        writes_rd       = funct7_ok;
      end
      rvx_isa_pkg::opcode_op_imm: begin
        decoded.use_immediate = 1'b1;
        decoded.illegal       = !funct7_ok;
        writes_rd             = funct7_ok;
      end
      rvx_isa_pkg::opcode_lui: begin
        decoded.wb_sel = rvx_exec_pkg::wb_upper_imm;
        writes_rd      = 1'b1;
      end
      rvx_isa_pkg::opcode_auipc: begin
        decoded.wb_sel = rvx_exec_pkg::wb_target;
        writes_rd      = 1'b1;
      end
      rvx_isa_pkg::opcode_jal: begin
        decoded.jump   = 1'b1;
        decoded.wb_sel = rvx_exec_pkg::wb_pc_step;
        writes_rd      = 1'b1;
      end
      rvx_isa_pkg::opcode_jalr: begin
        decoded.jump          = 1'b1;
        decoded.jump_register = 1'b1;
        decoded.wb_sel        = rvx_exec_pkg::wb_pc_step;
        writes_rd             = 1'b1;
      end
      rvx_isa_pkg::opcode_branch: begin
        case (decoded.branch_funct3)
          rvx_isa_pkg::beq, rvx_isa_pkg::bne, rvx_isa_pkg::blt,
          rvx_isa_pkg::bge, rvx_isa_pkg::bltu, rvx_isa_pkg::bgeu: decoded.branch = 1'b1;
          default: decoded.illegal = 1'b1;
        endcase
      end
      default: decoded.illegal = 1'b1;
    endcase
    // x0 is never written
    decoded.rd_write = writes_rd && (decoded.rd_address != '0);
  end

  always_comb begin
    assert (!(decoded.illegal && decoded.rd_write))
      else $error("decoder: illegal instruction requests a register write");
  end

endmodule

`default_nettype wire

// ==== src/rvx_exec.sv ====
/*
  Top of the RV32I execute unit: decoder feeding ALU and branch unit side by side,
  with the write-back block holding the result behind a req/ack handshake.
*/
`timescale 1ns/1ps
`default_nettype none

module rvx_exec (
  input  logic                        clock,
  input  logic                        reset_n,
  input  logic                        req,
  input  rvx_exec_pkg::exec_request_t request,
  output logic                        ack,
  output rvx_exec_pkg::exec_result_t  result
);

  rvx_exec_pkg::decoded_t decoded;
  logic [31:0]            immediate;
  logic [31:0]            alu_result;
  logic                   taken;
  logic [31:0]            target;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------

  rvx_decoder rvx_decoder_i (
    .instruction(request.instruction),
    .decoded    (decoded),
    .immediate  (immediate)
  );

  // --------------------------------------------------
  // Execute
  // --------------------------------------------------

  rvx_alu rvx_alu_i (
    .alu_op       (decoded.alu_op),
    .use_immediate(decoded.use_immediate),
    .rs1_data     (request.rs1_data),
    .rs2_data     (request.rs2_data),
    .immediate    (immediate),
    .alu_result   (alu_result)
  );

  rvx_branch rvx_branch_i (
    .branch       (decoded.branch),
    .jump         (decoded.jump),
    .jump_register(decoded.jump_register),
    .branch_funct3(decoded.branch_funct3),
    .pc           (request.pc),
    .rs1_data     (request.rs1_data),
    .rs2_data     (request.rs2_data),
    .immediate    (immediate),
    .taken        (taken),
    .target       (target)
  );

  // --------------------------------------------------
  // Write-back and handshake
  // --------------------------------------------------

  rvx_writeback rvx_writeback_i (
    .clock     (clock),
    .reset_n   (reset_n),
    .req       (req),
    .rd_address(decoded.rd_address),
    .rd_write  (decoded.rd_write),
    .illegal   (decoded.illegal),
    .wb_sel    (decoded.wb_sel),
    .pc        (request.pc),
    .alu_result(alu_result),
    .immediate (immediate),
    .target    (target),
    .taken     (taken),
    .ack       (ack),
    .result    (result)
  );

endmodule

`default_nettype wire

// ==== src/rvx_exec_pkg.sv ====
/*
  Types private to the execute unit: ALU and write-back selects, handshake state,
  and the packed structs passed between the blocks and to the requester.
*/
`default_nettype none

`include "rvx_config.svh"

package rvx_exec_pkg;

  // --------------------------------------------------
  // Internal encodings
  // --------------------------------------------------

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_e;

  // Source of the destination register value
  typedef enum logic [1:0] {
    wb_alu       = 2'd0,
    wb_upper_imm = 2'd1,
    wb_target    = 2'd2,
    wb_pc_step   = 2'd3
  } wb_sel_e;

  typedef enum logic {
    hs_idle  = 1'b0,
    hs_acked = 1'b1
  } handshake_state_e;

  // --------------------------------------------------
  // Structs
  // --------------------------------------------------

  typedef struct packed {
    logic [`RVX_INSTR_WIDTH-1:0] instruction;
    logic [`RVX_XLEN-1:0]        pc;
    logic [`RVX_XLEN-1:0]        rs1_data;
    logic [`RVX_XLEN-1:0]        rs2_data;
  } exec_request_t;

  typedef struct packed {
    alu_op_e                     alu_op;
    logic                        use_immediate;
    wb_sel_e                     wb_sel;
    logic                        branch;
    logic                        jump;
    logic                        jump_register;
    rvx_isa_pkg::branch_funct3_e branch_funct3;
    logic [`RVX_REG_ADDR_WIDTH-1:0] rd_address;
    logic                        rd_write;
    logic                        illegal;
  } decoded_t;

  typedef struct packed {
    logic [`RVX_REG_ADDR_WIDTH-1:0] rd_address;
    logic [`RVX_XLEN-1:0]           rd_data;
    logic                           rd_write;
    logic [`RVX_XLEN-1:0]           next_pc;
    logic                           illegal;
  } exec_result_t;

endpackage

`default_nettype wire

// ==== src/rvx_isa_pkg.sv ====
/*
  Encodings fixed by the RV32I base instruction set: major opcodes and funct3 fields.
*/
`default_nettype none

`include "rvx_config.svh"

package rvx_isa_pkg;

  // --------------------------------------------------
  // Major opcodes, instruction bits 6:0
  // --------------------------------------------------

  typedef enum logic [`RVX_OPCODE_WIDTH-1:0] {
    opcode_op     = 7'b0110011,
    opcode_op_imm = 7'b0010011,
    opcode_lui    = 7'b0110111,
    opcode_auipc  = 7'b0010111,
    opcode_jal    = 7'b1101111,
    opcode_jalr   = 7'b1100111,
    opcode_branch = 7'b1100011
  } opcode_e;

  // --------------------------------------------------
  // funct3 encodings, instruction bits 14:12
  // --------------------------------------------------

  // Conditional branches, 010 and 011 are reserved
  typedef enum logic [`RVX_FUNCT3_WIDTH-1:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_e;

  // Shared by OP and OP-IMM
  typedef enum logic [`RVX_FUNCT3_WIDTH-1:0] {
    funct3_add_sub = 3'b000,
    funct3_sll     = 3'b001,
    funct3_slt     = 3'b010,
    funct3_sltu    = 3'b011,
    funct3_xor     = 3'b100,
    funct3_srl_sra = 3'b101,
    funct3_or      = 3'b110,
    funct3_and     = 3'b111
  } alu_funct3_e;

endpackage

`default_nettype wire

// ==== src/rvx_writeback.sv ====
/*
  Write-back select, next program counter and the four-phase req/ack handshake.
  The result is captured once per transaction and held while ack is high.
*/
`timescale 1ns/1ps
`default_nettype none

`include "rvx_config.svh"

module rvx_writeback (
  input  logic                           clock,
  input  logic                           reset_n,
  input  logic                           req,
  input  logic [`RVX_REG_ADDR_WIDTH-1:0] rd_address,
  input  logic                           rd_write,
  input  logic                           illegal,
  input  rvx_exec_pkg::wb_sel_e          wb_sel,
  input  logic [`RVX_XLEN-1:0]           pc,
  input  logic [`RVX_XLEN-1:0]           alu_result,
  input  logic [`RVX_XLEN-1:0]           immediate,
  input  logic [`RVX_XLEN-1:0]           target,
  input  logic                           taken,
  output logic                           ack,
  output rvx_exec_pkg::exec_result_t     result
);

  rvx_exec_pkg::handshake_state_e state;
  rvx_exec_pkg::exec_result_t     next_result;
  logic [`RVX_XLEN-1:0]           pc_plus_step;
  logic [`RVX_XLEN-1:0]           rd_data;

  // --------------------------------------------------
  // Result forming
  // --------------------------------------------------

  assign pc_plus_step = pc + `RVX_XLEN'(`RVX_PC_STEP);

  always_comb begin
    case (wb_sel)
      rvx_exec_pkg::wb_alu:       rd_data = alu_result;
      rvx_exec_pkg::wb_upper_imm: rd_data = immediate;
      rvx_exec_pkg::wb_target:    rd_data = target;
      rvx_exec_pkg::wb_pc_step:   rd_data = pc_plus_step;
    endcase
  end

  assign next_result.rd_address = rd_address;
  assign next_result.rd_data    = rd_data;
  assign next_result.rd_write   = rd_write;
  assign next_result.next_pc    = taken ? target : pc_plus_step;
  assign next_result.illegal    = illegal;

  // --------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state  <= rvx_exec_pkg::hs_idle;
      result <= '0;
    end else begin
      case (state)
        rvx_exec_pkg::hs_idle: begin
          // Capture on the first edge that sees req
          if (req) begin
            result <= next_result;
            state  <= rvx_exec_pkg::hs_acked;
          end
        end
        rvx_exec_pkg::hs_acked: begin
          if (!req) begin
            state <= rvx_exec_pkg::hs_idle;
          end
        end
      endcase
    end
  end

  assign ack = (state == rvx_exec_pkg::hs_acked);

  // Handshake checks
  ack_needs_req: assert property (@(posedge clock) disable iff (!reset_n)
    $rose(ack) |-> $past(req))
    else $error("writeback: ack rose without req");

  // Held result still matches the request while req stays high
  result_held: assert property (@(posedge clock) disable iff (!reset_n)
    (ack && req) |-> (result == next_result))
    else $error("writeback: held result no longer matches the request");

endmodule

`default_nettype wire
